// ==== all.f ====
+incdir+hdl
hdl/ray_pkg.sv
hdl/pixel_scanner.sv
hdl/inv_sqrt.sv
hdl/ray_generator.sv
hdl/ray_output.sv
hdl/ray_frontend_top.sv
test/ray_frontend_assert.sv
test/ray_frontend_tb.sv

// ==== hdl/inv_sqrt.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

module inv_sqrt (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_in,
    input  ray_pkg::fp x,
    output logic       valid_out,
    output ray_pkg::fp inv_sqrt
);

    // 1/sqrt(2^b * m) at the middle of each quarter of the mantissa
    // index is {exponent parity, two bits below the leading one}
    localparam ray_pkg::fp SEED_TAB [8] = '{
        ray_pkg::fp'(0.942809 * 16777216.0),
        ray_pkg::fp'(0.852803 * 16777216.0),
        ray_pkg::fp'(0.784465 * 16777216.0),
        ray_pkg::fp'(0.730297 * 16777216.0),
        ray_pkg::fp'(0.666667 * 16777216.0),
        ray_pkg::fp'(0.603023 * 16777216.0),
        ray_pkg::fp'(0.554700 * 16777216.0),
        ray_pkg::fp'(0.516398 * 16777216.0)
    };

    // x * y^2, two multiplies in series
    function automatic ray_pkg::fp scaled_sq(input ray_pkg::fp xv, input ray_pkg::fp yv);
        return ray_pkg::fp_mul(xv, ray_pkg::fp_mul(yv, yv));
    endfunction

    // y * (1.5 - 0.5 * x * y^2)
    function automatic ray_pkg::fp newton_update(input ray_pkg::fp yv, input ray_pkg::fp xyy);
        return ray_pkg::fp_mul(yv, ray_pkg::fp'(`FP_THREE_HALVES) - (xyy >>> 1));
    endfunction

    logic [4:0]        lead;
    logic [31:0]       norm;
    logic signed [5:0] half_exp;
    ray_pkg::fp        base;
    ray_pkg::fp        seed;

    // stage registers, s0 seed, s1/s2 first step, s3/s4 second step
    ray_pkg::fp x0, x1, x2;
    ray_pkg::fp y0, y1, y2, y3;
    ray_pkg::fp xy1, xy3;
    logic [4:0] vld;

    // leading one gives the exponent, halved for the root
    always_comb begin
        lead = '0;
        for (int i = 0; i < 31; i++) begin
            if (x[i]) lead = 5'(i);
        end
        norm     = x << (5'd31 - lead);
        half_exp = ($signed({1'b0, lead}) - 6'sd24) >>> 1;
        base     = SEED_TAB[{lead[0], norm[30:29]}];
        // power of two scale, inputs below 2^-6 fall outside the seed range
        seed     = half_exp[5] ? base << (-half_exp) : base >> half_exp;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[3:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        x0       <= x;
        y0       <= seed;
        // first newton step
        x1       <= x0;
        y1       <= y0;
        xy1      <= scaled_sq(x0, y0);
        x2       <= x1;
        y2       <= newton_update(y1, xy1);
        // second newton step
        y3       <= y2;
        xy3      <= scaled_sq(x2, y2);
        inv_sqrt <= newton_update(y3, xy3);
    end

    assign valid_out = vld[4];

endmodule

// ==== hdl/pixel_scanner.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

module pixel_scanner (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  ray_pkg::scan_window   window,
    output ray_pkg::pixel_tag     pix,
    output logic                  pix_valid,
    output logic                  busy
);

    // window held for the whole scan
    ray_pkg::scan_window win;

    logic [`COORD_W-1:0] col_end;
    logic [`COORD_W-1:0] row_end;
    logic [`COORD_W-1:0] next_col;
    logic [`COORD_W-1:0] next_row;
    logic                at_row_end;

    // next position in row-major order
    always_comb begin
        col_end    = win.x0 + win.w;
        row_end    = win.y0 + win.h;
        at_row_end = (pix.col == col_end);
        // wrap to the start of the next row
        next_col   = at_row_end ? win.x0 : pix.col + 1'b1;
        next_row   = at_row_end ? pix.row + 1'b1 : pix.row;
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            win <= window;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pix       <= '0;
            pix_valid <= 1'b0;
            busy      <= 1'b0;
        end else if (!busy) begin
            // start only taken when idle
            if (start) begin
                pix.col   <= window.x0;
                pix.row   <= window.y0;
                pix.last  <= (window.w == '0) && (window.h == '0);
                pix_valid <= 1'b1;
                busy      <= 1'b1;
            end
        end else if (pix.last) begin
            // final pixel just went out
            pix_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            pix.col  <= next_col;
            pix.row  <= next_row;
            pix.last <= (next_col == col_end) && (next_row == row_end);
        end
    end

endmodule

// ==== hdl/ray_frontend_top.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

module ray_frontend_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  ray_pkg::scan_window     window,
    // held stable while busy
    input  ray_pkg::vec3            camera_forward,
    output logic                    busy,
    output ray_pkg::vec3            out_ray,
    output ray_pkg::pixel_tag       out_tag,
    output logic                    out_valid,
    output logic                    frame_done,
    output logic [`RAY_COUNT_W-1:0] ray_count
);

    ray_pkg::pixel_tag pix;
    logic              pix_valid;
    ray_pkg::vec3      dir;
    ray_pkg::pixel_tag dir_tag;
    logic              dir_valid;

    pixel_scanner scanner0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .window    (window),
        .pix       (pix),
        .pix_valid (pix_valid),
        .busy      (busy)
    );

    ray_generator generator0 (
        .clk            (clk),
        .rst            (rst),
        .pix            (pix),
        .pix_valid      (pix_valid),
        .camera_forward (camera_forward),
        .dir            (dir),
        .dir_tag        (dir_tag),
        .dir_valid      (dir_valid)
    );

    ray_output output0 (
        .clk        (clk),
        .rst        (rst),
        .dir        (dir),
        .dir_tag    (dir_tag),
        .dir_valid  (dir_valid),
        .out_ray    (out_ray),
        .out_tag    (out_tag),
        .out_valid  (out_valid),
        .frame_done (frame_done),
        .ray_count  (ray_count)
    );

endmodule

// ==== hdl/ray_generator.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

module ray_generator (
    input  logic              clk,
    input  logic              rst,
    input  ray_pkg::pixel_tag pix,
    input  logic              pix_valid,
    input  ray_pkg::vec3      camera_forward,
    output ray_pkg::vec3      dir,
    output ray_pkg::pixel_tag dir_tag,
    output logic              dir_valid
);

    // fixed camera basis
    localparam ray_pkg::vec3 CAM_RIGHT = '{x: `FP_ONE, y: '0, z: '0};
    localparam ray_pkg::vec3 CAM_UP    = '{x: '0, y: `FP_ONE, z: '0};

    // ray and its pixel travel together past the inverse root
    typedef struct packed {
        ray_pkg::vec3      ray;
        ray_pkg::pixel_tag tag;
    } ray_entry;

    logic              v1, v2, v3;
    ray_pkg::fp        ndc_x, ndc_y;
    ray_pkg::pixel_tag tag1, tag2;
    ray_pkg::vec3      ray2;
    ray_entry          ent3;
    ray_pkg::fp        mag_sq;
    ray_entry          dly [`INV_SQRT_LATENCY];
    ray_pkg::fp        inv_mag;
    logic              inv_valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            v3        <= 1'b0;
            dir_valid <= 1'b0;
        end else begin
            v1        <= pix_valid;
            v2        <= v1;
            v3        <= v2;
            dir_valid <= inv_valid;
        end
    end

    // stage 1, pixel to ndc in [-1,1]
    // integer times 8.24 scale is already 8.24
    always_ff @(posedge clk) begin
        ndc_x <= ray_pkg::fp'(32'(pix.col)) * ray_pkg::fp'(`SCALE_X) - ray_pkg::fp'(`FP_ONE);
        ndc_y <= ray_pkg::fp'(`FP_ONE) - ray_pkg::fp'(32'(pix.row)) * ray_pkg::fp'(`SCALE_Y);
        tag1  <= pix;
    end

    // stage 2, right * ndc_x + up * ndc_y - forward
    always_ff @(posedge clk) begin
        ray2.x <= ray_pkg::fp_mul(ndc_x, CAM_RIGHT.x) + ray_pkg::fp_mul(ndc_y, CAM_UP.x)
                  - camera_forward.x;
        ray2.y <= ray_pkg::fp_mul(ndc_x, CAM_RIGHT.y) + ray_pkg::fp_mul(ndc_y, CAM_UP.y)
                  - camera_forward.y;
        ray2.z <= ray_pkg::fp_mul(ndc_x, CAM_RIGHT.z) + ray_pkg::fp_mul(ndc_y, CAM_UP.z)
                  - camera_forward.z;
        tag2   <= tag1;
    end

    // stage 3, squared length
    always_ff @(posedge clk) begin
        mag_sq   <= ray_pkg::vec3_dot(ray2, ray2);
        ent3.ray <= ray2;
        ent3.tag <= tag2;
    end

    inv_sqrt inv_sqrt0 (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (v3),
        .x         (mag_sq),
        .valid_out (inv_valid),
        .inv_sqrt  (inv_mag)
    );

    // delay line matches the inverse root depth
    always_ff @(posedge clk) begin
        dly[0] <= ent3;
        for (int i = 1; i < `INV_SQRT_LATENCY; i++) begin
            dly[i] <= dly[i-1];
        end
    end

    // last stage, scale each component to unit length
    always_ff @(posedge clk) begin
        dir.x   <= ray_pkg::fp_mul(dly[`INV_SQRT_LATENCY-1].ray.x, inv_mag);
        dir.y   <= ray_pkg::fp_mul(dly[`INV_SQRT_LATENCY-1].ray.y, inv_mag);
        dir.z   <= ray_pkg::fp_mul(dly[`INV_SQRT_LATENCY-1].ray.z, inv_mag);
        dir_tag <= dly[`INV_SQRT_LATENCY-1].tag;
    end

endmodule

// ==== hdl/ray_macros.svh ====
`ifndef RAY_MACROS_SVH
`define RAY_MACROS_SVH

// screen size in pixels
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// pixel coordinate and ray counter widths
`define COORD_W 10
`define RAY_COUNT_W 20

// 8.24 constants
`define FP_ONE 32'h01000000
`define FP_THREE_HALVES 32'h01800000

// 2/width and 2/height, rounded to nearest
`define SCALE_X 32'h0000CCCD
`define SCALE_Y 32'h00011111

// pipeline depths
`define INV_SQRT_LATENCY 5
// ndc, ray, length squared, inverse root, normalize
`define RAY_GEN_LATENCY (3 + `INV_SQRT_LATENCY + 1)

`endif

// ==== hdl/ray_output.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

module ray_output (
    input  logic                    clk,
    input  logic                    rst,
    input  ray_pkg::vec3            dir,
    input  ray_pkg::pixel_tag       dir_tag,
    input  logic                    dir_valid,
    output ray_pkg::vec3            out_ray,
    output ray_pkg::pixel_tag       out_tag,
    output logic                    out_valid,
    output logic                    frame_done,
    output logic [`RAY_COUNT_W-1:0] ray_count
);

    // next ray starts a new window
    logic new_frame;

    always_ff @(posedge clk) begin
        if (dir_valid) begin
            out_ray <= dir;
            out_tag <= dir_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            frame_done <= 1'b0;
            ray_count  <= '0;
            new_frame  <= 1'b1;
        end else begin
            out_valid  <= dir_valid;
            frame_done <= dir_valid && dir_tag.last;
            if (dir_valid) begin
                // count is the position of this ray, first one is 1
                ray_count <= new_frame ? `RAY_COUNT_W'(1) : ray_count + 1'b1;
                new_frame <= dir_tag.last;
            end
        end
    end

endmodule

// ==== hdl/ray_pkg.sv ====
`include "ray_macros.svh"

package ray_pkg;

    // signed 8.24 fixed point
    typedef logic signed [31:0] fp;

    // three component vector, x in the top word
    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // pixel position plus end of window marker
    typedef struct packed {
        logic [`COORD_W-1:0] col;
        logic [`COORD_W-1:0] row;
        logic                last;
    } pixel_tag;

    // window origin and extent
    // extent counts extra pixels, so zero is a single pixel
    typedef struct packed {
        logic [`COORD_W-1:0] x0;
        logic [`COORD_W-1:0] y0;
        logic [`COORD_W-1:0] w;
        logic [`COORD_W-1:0] h;
    } scan_window;

    // 8.24 product
    // full 64-bit product, keep bits 55..24, rounds toward minus infinity
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[55:24];
    endfunction

    // sum of componentwise products
    function automatic fp vec3_dot(input vec3 a, input vec3 b);
        fp acc;
        acc = fp_mul(a.x, b.x);
        acc = acc + fp_mul(a.y, b.y);
        acc = acc + fp_mul(a.z, b.z);
        return acc;
    endfunction

endpackage

// ==== test/ray_frontend_assert.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

// watches the scanner and generator strobes from the top level
module ray_frontend_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic pix_valid,
    input logic busy,
    input logic dir_valid
);

    // failure count, read back by the testbench
    int assert_fails = 0;

    // scan opens only on a start, with busy already up
    pix_after_start: assert property (@(posedge clk) disable iff (!rst)
        $rose(pix_valid) |-> busy && $past(start))
        else begin
            $error("pix_valid rose without a start");
            assert_fails++;
        end

    // fixed generator depth
    pix_to_dir: assert property (@(posedge clk) disable iff (!rst)
        pix_valid |-> ##`RAY_GEN_LATENCY dir_valid)
        else begin
            $error("dir_valid missing after pix_valid");
            assert_fails++;
        end

    // no ray without its pixel
    dir_has_pix: assert property (@(posedge clk) disable iff (!rst)
        dir_valid |-> $past(pix_valid, `RAY_GEN_LATENCY))
        else begin
            $error("dir_valid without an earlier pix_valid");
            assert_fails++;
        end

endmodule

bind ray_frontend_top ray_frontend_assert chk0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .pix_valid (pix_valid),
    .busy      (busy),
    .dir_valid (dir_valid)
);

// ==== test/ray_frontend_tb.sv ====
`timescale 1ns/1ps
`include "ray_macros.svh"

module ray_frontend_tb;

    localparam int  NUM_TESTS        = 4;
    localparam int  WAIT_LIMIT       = 40;
    localparam int  FIRST_RAY_CYCLES = 11;
    localparam real FP_SCALE         = 16777216.0;
    // 2^-10 per component, 2^-9 on the squared length
    localparam real COMP_TOL         = 1.0 / 1024.0;
    localparam real LEN_TOL          = 1.0 / 512.0;

    // window offered while busy, must be ignored
    localparam ray_pkg::scan_window JUNK_WIN = '{x0: 10'd7, y0: 10'd9, w: 10'd2, h: 10'd2};

    logic                    clk;
    logic                    rst;
    logic                    start;
    ray_pkg::scan_window     window;
    ray_pkg::vec3            camera_forward;
    logic                    busy;
    ray_pkg::vec3            out_ray;
    ray_pkg::pixel_tag       out_tag;
    logic                    out_valid;
    logic                    frame_done;
    logic [`RAY_COUNT_W-1:0] ray_count;

    // stimulus table, one window and forward vector per entry
    string               test_name [NUM_TESTS];
    ray_pkg::scan_window win_tab   [NUM_TESTS];
    ray_pkg::vec3        fwd_tab   [NUM_TESTS];

    int value_errors;
    int protocol_errors;
    int assert_count;
    bit aborted;

    ray_frontend_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .window         (window),
        .camera_forward (camera_forward),
        .busy           (busy),
        .out_ray        (out_ray),
        .out_tag        (out_tag),
        .out_valid      (out_valid),
        .frame_done     (frame_done),
        .ray_count      (ray_count)
    );

    always #2 clk = ~clk;

    function automatic real to_real(input ray_pkg::fp v);
        return real'(v) / FP_SCALE;
    endfunction

    function automatic real abs_real(input real v);
        return (v < 0.0) ? -v : v;
    endfunction

    // unit view ray for one pixel, right (1,0,0), up (0,1,0)
    task automatic model_ray(input int col, input int row, input ray_pkg::vec3 fwd,
                             output real ex, output real ey, output real ez);
        real rx, ry, rz, mag;
        rx  = col * to_real(`SCALE_X) - 1.0 - to_real(fwd.x);
        ry  = 1.0 - row * to_real(`SCALE_Y) - to_real(fwd.y);
        rz  = -to_real(fwd.z);
        mag = $sqrt(rx * rx + ry * ry + rz * rz);
        ex  = rx / mag;
        ey  = ry / mag;
        ez  = rz / mag;
    endtask

    task automatic report_int(input string name, input string what, input int exp_v,
                              input int act_v);
        $display("FAILED %s %s expected %0d actual %0d", name, what, exp_v, act_v);
        value_errors++;
    endtask

    task automatic report_real(input string name, input string what, input real exp_v,
                               input real act_v);
        $display("FAILED %s %s expected %f actual %f", name, what, exp_v, act_v);
        value_errors++;
    endtask

    // one table entry, start pulse then the whole window of rays
    task automatic run_entry(input int t);
        ray_pkg::scan_window win;
        string               name;
        int                  n;
        int                  lat;
        int                  idx;
        int                  exp_col;
        int                  exp_row;
        real                 ex, ey, ez, ax, ay, az, len_sq;
        win  = win_tab[t];
        name = test_name[t];
        n    = (win.w + 1) * (win.h + 1);
        @(negedge clk);
        window         = win;
        camera_forward = fwd_tab[t];
        start          = 1'b1;
        lat            = 0;
        // count cycles to the first ray
        do begin
            @(negedge clk);
            lat++;
            if (lat == 1 && !busy) begin
                $display("busy did not rise after start in %s", name);
                protocol_errors++;
            end
            // second start during the scan, other window
            start  = (lat == 2) && busy;
            window = start ? JUNK_WIN : win;
        end while (!out_valid && lat < WAIT_LIMIT);
        start  = 1'b0;
        window = win;
        if (!out_valid) begin
            $display("timeout waiting for the first ray of %s", name);
            protocol_errors++;
            aborted = 1'b1;
            return;
        end
        if (lat != FIRST_RAY_CYCLES) report_int(name, "first ray latency", FIRST_RAY_CYCLES, lat);
        for (idx = 0; idx < n; idx++) begin
            if (idx > 0) @(negedge clk);
            if (!out_valid) begin
                $display("out_valid dropped at ray %0d of %s", idx, name);
                protocol_errors++;
                break;
            end
            // row-major walk from the window origin
            exp_col = win.x0 + idx % (win.w + 1);
            exp_row = win.y0 + idx / (win.w + 1);
            if (out_tag.col != exp_col) report_int(name, "col", exp_col, out_tag.col);
            if (out_tag.row != exp_row) report_int(name, "row", exp_row, out_tag.row);
            // last flag and frame_done only on the final pixel
            if (out_tag.last != (idx == n - 1)) begin
                report_int(name, "last", idx == n - 1, out_tag.last);
            end
            if (frame_done != (idx == n - 1)) begin
                report_int(name, "frame_done", idx == n - 1, frame_done);
            end
            if (ray_count != idx + 1) report_int(name, "ray_count", idx + 1, ray_count);
            model_ray(exp_col, exp_row, fwd_tab[t], ex, ey, ez);
            ax = to_real(out_ray.x);
            ay = to_real(out_ray.y);
            az = to_real(out_ray.z);
            if (abs_real(ax - ex) > COMP_TOL) report_real(name, "ray x", ex, ax);
            if (abs_real(ay - ey) > COMP_TOL) report_real(name, "ray y", ey, ay);
            if (abs_real(az - ez) > COMP_TOL) report_real(name, "ray z", ez, az);
            len_sq = ax * ax + ay * ay + az * az;
            if (abs_real(len_sq - 1.0) > LEN_TOL) report_real(name, "length squared", 1.0, len_sq);
        end
        // stream ends on the last pixel
        @(negedge clk);
        if (out_valid) begin
            $display("extra ray after the window of %s", name);
            protocol_errors++;
        end
        if (frame_done) begin
            $display("frame_done held past the last ray of %s", name);
            protocol_errors++;
        end
        if (busy) begin
            $display("busy still high after the window of %s", name);
            protocol_errors++;
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b0;
        start           = 1'b0;
        window          = '0;
        camera_forward  = '0;
        value_errors    = 0;
        protocol_errors = 0;
        aborted         = 1'b0;

        test_name[0] = "corner_4x3";
        win_tab[0]   = '{x0: 10'd0, y0: 10'd0, w: 10'd3, h: 10'd2};
        fwd_tab[0]   = '{x: '0, y: '0, z: `FP_ONE};
        test_name[1] = "centre_pixel";
        win_tab[1]   = '{x0: 10'd320, y0: 10'd240, w: 10'd0, h: 10'd0};
        fwd_tab[1]   = '{x: '0, y: '0, z: `FP_ONE};
        test_name[2] = "bottom_right_strip";
        win_tab[2]   = '{x0: 10'd632, y0: 10'd478, w: 10'd7, h: 10'd1};
        fwd_tab[2]   = '{x: '0, y: '0, z: 32'h02000000};
        test_name[3] = "column_1x5";
        win_tab[3]   = '{x0: 10'd100, y0: 10'd200, w: 10'd0, h: 10'd4};
        fwd_tab[3]   = '{x: '0, y: '0, z: -`FP_ONE};

        repeat (4) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        if (busy || out_valid || frame_done || ray_count != 0) begin
            $display("outputs not idle after reset");
            protocol_errors++;
        end

        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            run_entry(t);
        end

        assert_count = dut0.chk0.assert_fails;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, assert_count);
        if (value_errors + protocol_errors + assert_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
